/* hw/vchan_pkg.sv */
// shared widths, channel count and beat types; imported by every vchan module

package vchan_pkg;

    // ========================================
    // channel count and widths
    // ========================================

    // number of virtual channels on the shared link
    localparam int NUM_CHANNELS = 4;

    // tag width follows the channel count
    localparam int TAG_W = $clog2(NUM_CHANNELS);

    // user payload below the tag
    localparam int PAYLOAD_W = 30;

    // full beat data: tag on top, payload below
    localparam int DATA_W = TAG_W + PAYLOAD_W;

    // ========================================
    // types
    // ========================================

    // channel number, also the egress port index
    typedef logic [TAG_W-1:0] vchan_tag_t;

    // beat data, top TAG_W bits carry the tag
    typedef logic [DATA_W-1:0] vchan_data_t;

    // one beat of any stream
    typedef struct packed {
        vchan_data_t data;
        // end of packet
        logic        last;
    } vchan_beat_t;

    // one beat per channel
    typedef vchan_beat_t [NUM_CHANNELS-1:0] vchan_beat_vec_t;

    // per-channel valid, ready, sop and grant
    typedef logic [NUM_CHANNELS-1:0] vchan_mask_t;

    // tag field of a beat
    function automatic vchan_tag_t beat_tag(input vchan_beat_t beat);
        return beat.data[DATA_W-1 -: TAG_W];
    endfunction

endpackage

/* hw/vchan_ingress.sv */
// input side of the link mux; tracks per-channel start of packet for the arbiter

`timescale 1ns/10ps

module vchan_ingress
    import vchan_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,

    // per-channel source streams
    input  vchan_beat_vec_t in_beat,
    input  vchan_mask_t     in_valid,
    output vchan_mask_t     in_ready,

    // requests toward the arbiter
    output vchan_beat_vec_t req_beat,
    output vchan_mask_t     req_valid,
    output vchan_mask_t     req_sop,
    input  vchan_mask_t     req_ready
);

    // ========================================
    // start-of-packet tracking
    // ========================================

    // high while the next beat of a channel opens a packet
    vchan_mask_t sop_q;

    // handshake per channel
    vchan_mask_t accepted;

    assign accepted = in_valid & req_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // every channel starts at a packet boundary
            sop_q <= '1;
        end
        else
        begin
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                // last beat accepted -> next one is a new packet
                if (accepted[c])
                begin
                    sop_q[c] <= in_beat[c].last;
                end
            end
        end
    end

    // ========================================
    // request outputs
    // ========================================

    // beats go on unchanged, the writer already put the tag in
    assign req_beat  = in_beat;
    assign req_valid = in_valid;

    // sop only counts with a beat present
    assign req_sop   = sop_q & in_valid;

    // ready comes straight from the arbiter grant
    assign in_ready  = req_ready;

endmodule

/* hw/vchan_pkt_arb.sv */
// packet-atomic round-robin arbiter; picks one channel per packet and registers it onto the link

`timescale 1ns/10ps

module vchan_pkt_arb
    import vchan_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,

    // per-channel requests from ingress
    input  vchan_beat_vec_t req_beat,
    input  vchan_mask_t     req_valid,
    input  vchan_mask_t     req_sop,
    output vchan_mask_t     req_ready,

    // shared link
    output vchan_beat_t     link_beat,
    output logic            link_valid,
    input  logic            link_ready
);

    // idle: free to pick a new packet; locked: inside a packet
    typedef enum logic {
        ST_IDLE,
        ST_LOCKED
    } arb_state_t;

    arb_state_t  state;

    // channel holding the lock
    vchan_tag_t  lock_ch;

    // first channel searched on the next pick
    vchan_tag_t  rr_ptr;

    // result of the round-robin search
    logic        found;
    vchan_tag_t  win_ch;

    // channel whose beat feeds the register this cycle
    vchan_tag_t  sel_ch;
    vchan_tag_t  next_ptr;
    vchan_beat_t sel_beat;

    logic        can_load;
    logic        accept;

    // ========================================
    // round-robin search
    // ========================================

    always_comb
    begin : win_search
        vchan_tag_t idx;

        found  = 1'b0;
        win_ch = rr_ptr;
        // upward from rr_ptr, wraps at the tag width
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            idx = rr_ptr + vchan_tag_t'(i);
            if (!found && req_valid[idx] && req_sop[idx])
            begin
                found  = 1'b1;
                win_ch = idx;
            end
        end
    end

    // register empty or draining this cycle
    assign can_load = !link_valid || link_ready;

    assign sel_ch   = (state == ST_LOCKED) ? lock_ch : win_ch;
    assign sel_beat = req_beat[sel_ch];
    assign next_ptr = sel_ch + 1'b1;

    // grant goes to one channel only
    always_comb
    begin
        req_ready = '0;
        if (can_load)
        begin
            if (state == ST_LOCKED)
                req_ready[lock_ch] = 1'b1;
            else if (found)
                req_ready[win_ch] = 1'b1;
        end
    end

    assign accept = |(req_ready & req_valid);

    // ========================================
    // lock FSM and round-robin pointer
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state   <= ST_IDLE;
            lock_ch <= '0;
            rr_ptr  <= '0;
        end
        else if (accept)
        begin
            if (sel_beat.last)
            begin
                // packet done, next search starts after the winner
                state  <= ST_IDLE;
                rr_ptr <= next_ptr;
            end
            else if (state == ST_IDLE)
            begin
                state   <= ST_LOCKED;
                lock_ch <= win_ch;
            end
        end
    end

    // ========================================
    // one-beat output register
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            link_valid <= 1'b0;
        else if (accept)
            link_valid <= 1'b1;
        else if (link_ready)
            link_valid <= 1'b0;
    end

    // payload loads with the grant, holds under back-pressure
    always_ff @(posedge clk)
    begin
        if (accept)
            link_beat <= sel_beat;
    end

endmodule

/* hw/vchan_egress.sv */
// output side of the link; steers each link beat to the port named by its tag

`timescale 1ns/10ps

module vchan_egress
    import vchan_pkg::*;
(
    // shared link from the arbiter
    input  vchan_beat_t link_beat,
    input  logic        link_valid,
    output logic        link_ready,

    // per-port sink streams, beat shared by all ports
    output vchan_beat_t out_beat,
    output vchan_mask_t out_valid,
    input  vchan_mask_t out_ready
);

    // ========================================
    // tag decode
    // ========================================

    // port named by the current link beat
    vchan_tag_t link_tag;

    assign link_tag = beat_tag(link_beat);

    // one-hot valid toward the tagged port
    always_comb
    begin
        out_valid = '0;
        for (int p = 0; p < NUM_CHANNELS; p++)
        begin
            if (link_tag == vchan_tag_t'(p))
                out_valid[p] = link_valid;
        end
    end

    // ========================================
    // ready return and beat fan-out
    // ========================================

    // only the addressed sink can stall the link
    assign link_ready = out_ready[link_tag];

    // sinks without valid ignore the beat
    assign out_beat   = link_beat;

endmodule

/* hw/vchan_link_top.sv */
// top level of the virtual channel link; ingress, arbiter and egress over one shared link

`timescale 1ns/10ps

module vchan_link_top
    import vchan_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,

    // per-channel sources, tag already in the data
    input  vchan_beat_vec_t in_beat,
    input  vchan_mask_t     in_valid,
    output vchan_mask_t     in_ready,

    // per-port sinks
    output vchan_beat_t     out_beat,
    output vchan_mask_t     out_valid,
    input  vchan_mask_t     out_ready
);

    // ingress to arbiter
    vchan_beat_vec_t req_beat;
    vchan_mask_t     req_valid;
    vchan_mask_t     req_sop;
    vchan_mask_t     req_ready;

    // internal shared link
    vchan_beat_t     link_beat;
    logic            link_valid;
    logic            link_ready;

    // ========================================
    // datapath
    // ========================================

    vchan_ingress u_vchan_ingress (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .req_beat  (req_beat),
        .req_valid (req_valid),
        .req_sop   (req_sop),
        .req_ready (req_ready)
    );

    // one cycle from request to link
    vchan_pkt_arb u_vchan_pkt_arb (
        .clk        (clk),
        .reset_n    (reset_n),
        .req_beat   (req_beat),
        .req_valid  (req_valid),
        .req_sop    (req_sop),
        .req_ready  (req_ready),
        .link_beat  (link_beat),
        .link_valid (link_valid),
        .link_ready (link_ready)
    );

    vchan_egress u_vchan_egress (
        .link_beat  (link_beat),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

/* sim/vchan_tb.sv */
// virtual channel link testbench; seeded random packets checked against per-channel queues

`timescale 1ns/10ps

module vchan_tb
    import vchan_pkg::*;
();

    // packets per channel set the phase lengths and the watchdog
    localparam int NUM_PKTS    = 40;
    localparam int RAND_CYCLES = NUM_PKTS * 20;
    localparam int FAIR_CYCLES = NUM_PKTS * 10;
    localparam longint WATCHDOG_NS = NUM_PKTS * 6 * NUM_CHANNELS * 20 * 4;

    // off mode holds valid low
    // drain mode stops new beats and keeps every sink ready
    typedef enum int {MODE_OFF, MODE_RANDOM, MODE_FAIR, MODE_DRAIN} stim_mode_t;

    logic            clk;
    logic            reset_n;
    vchan_beat_vec_t in_beat;
    vchan_mask_t     in_valid;
    vchan_mask_t     in_ready;
    vchan_beat_t     out_beat;
    vchan_mask_t     out_valid;
    vchan_mask_t     out_ready;

    integer          seed;
    stim_mode_t      mode;
    // source state per channel
    vchan_beat_vec_t drv_beat;
    vchan_mask_t     drv_valid;
    vchan_mask_t     in_fire;
    int              src_left [NUM_CHANNELS];
    logic [PAYLOAD_W-1:0] seq [NUM_CHANNELS];
    // reference model
    vchan_beat_t     exp_q [NUM_CHANNELS][$];
    int              sent_count;
    int              recv_count;
    logic            pkt_open;
    vchan_tag_t      open_ch;
    vchan_tag_t      prev_ch;
    logic            fair_check;
    // stall hold tracking
    logic            hold_pending;
    vchan_beat_t     held_beat;
    vchan_mask_t     held_valid;

    vchan_link_top u_vchan_link_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // failure reporting and compares
    // ========================================

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_beat(input string name, input vchan_beat_t got, input vchan_beat_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_mask(input string name, input vchan_mask_t got, input vchan_mask_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    function automatic int queued_beats();
        int n;
        n = 0;
        for (int c = 0; c < NUM_CHANNELS; c++)
            n += exp_q[c].size();
        return n;
    endfunction

    // pop and compare one egress beat and track packet order
    task automatic check_egress(input int p);
        vchan_beat_t exp;
        if (exp_q[p].size() == 0)
        begin
            $display("beat arrived on egress port %0d with nothing sent on that channel", p);
            report_failure();
        end
        exp = exp_q[p].pop_front();
        recv_count++;
        check_beat("out_beat", out_beat, exp);
        if (pkt_open)
        begin
            // only the open packet's channel may appear
            check_mask("out_valid", out_valid, vchan_mask_t'(1) << open_ch);
        end
        else
        begin
            // a new packet follows the previous one in round-robin order
            if (fair_check)
                check_mask("out_valid", out_valid,
                           vchan_mask_t'(1) << vchan_tag_t'(prev_ch + 1'b1));
            else
                check_mask("out_valid", out_valid, vchan_mask_t'(1) << p);
            open_ch  = vchan_tag_t'(p);
            pkt_open = 1'b1;
        end
        if (exp.last)
        begin
            pkt_open = 1'b0;
            prev_ch  = open_ch;
        end
    endtask

    // ========================================
    // stimulus driven on the rising edge
    // ========================================

    always @(posedge clk)
    begin : drive_sources
        vchan_beat_t beat;
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            if (mode == MODE_OFF || in_fire[c])
                drv_valid[c] = 1'b0;
            // a held beat stays until it transfers
            if (!drv_valid[c] && (mode == MODE_FAIR ||
                (mode == MODE_RANDOM && ($random(seed) & 3) != 0)))
            begin
                if (src_left[c] == 0)
                    src_left[c] = 1 + ($unsigned($random(seed)) % 6);
                beat.data    = {vchan_tag_t'(c), seq[c]};
                beat.last    = (src_left[c] == 1);
                src_left[c]  = src_left[c] - 1;
                seq[c]       = seq[c] + 1'b1;
                drv_beat[c]  = beat;
                drv_valid[c] = 1'b1;
            end
        end
        in_beat  <= drv_beat;
        in_valid <= drv_valid;
        if (mode == MODE_RANDOM)
            out_ready <= vchan_mask_t'($random(seed));
        else if (mode != MODE_OFF)
            out_ready <= '1;
    end

    // ========================================
    // monitor sampling settled values mid-cycle
    // ========================================

    always @(negedge clk)
    begin : monitor
        vchan_mask_t out_fire;
        if (!reset_n)
        begin
            // reset drops everything in flight
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                exp_q[c].delete();
                src_left[c] = 0;
            end
            in_fire      = '0;
            sent_count   = 0;
            recv_count   = 0;
            pkt_open     = 1'b0;
            prev_ch      = vchan_tag_t'(NUM_CHANNELS - 1);
            hold_pending = 1'b0;
        end
        else
        begin
            in_fire  = in_valid & in_ready;
            out_fire = out_valid & out_ready;
            // stalled link must not move
            if (hold_pending)
            begin
                check_beat("out_beat", out_beat, held_beat);
                check_mask("out_valid", out_valid, held_valid);
            end
            hold_pending = (out_valid != '0) && (out_fire == '0);
            held_beat    = out_beat;
            held_valid   = out_valid;
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                if (in_fire[c])
                begin
                    exp_q[c].push_back(in_beat[c]);
                    sent_count++;
                end
            end
            for (int p = 0; p < NUM_CHANNELS; p++)
            begin
                if (out_fire[p])
                    check_egress(p);
            end
        end
    end

    // ========================================
    // test sequence
    // ========================================

    initial
    begin
        seed       = 32'h699e;
        mode       = MODE_OFF;
        reset_n    = 1'b0;
        in_beat    = '0;
        in_valid   = '0;
        out_ready  = '0;
        drv_beat   = '0;
        drv_valid  = '0;
        in_fire    = '0;
        fair_check = 1'b0;
        for (int c = 0; c < NUM_CHANNELS; c++)
            seq[c] = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_mask("in_ready", in_ready, '0);
        check_mask("out_valid", out_valid, '0);
        // random valid and sink stalls
        @(posedge clk);
        mode <= MODE_RANDOM;
        repeat (RAND_CYCLES) @(posedge clk);
        // all channels busy and all sinks ready
        mode <= MODE_FAIR;
        repeat (20) @(posedge clk);
        fair_check = 1'b1;
        repeat (FAIR_CYCLES) @(posedge clk);
        // reset in the middle of traffic
        reset_n <= 1'b0;
        mode    <= MODE_OFF;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_mask("in_ready", in_ready, '0);
        check_mask("out_valid", out_valid, '0);
        // first packet after reset has to be channel 0
        @(posedge clk);
        mode <= MODE_FAIR;
        repeat (FAIR_CYCLES / 2) @(posedge clk);
        fair_check = 1'b0;
        mode <= MODE_DRAIN;
        repeat (20) @(posedge clk);
        while (queued_beats() != 0)
            @(posedge clk);
        if (sent_count == recv_count && recv_count > 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("beat counts differ: sent %0d received %0d", sent_count, recv_count);
            report_failure();
        end
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        report_failure();
    end

endmodule

/* list.f */
hw/vchan_pkg.sv
hw/vchan_ingress.sv
hw/vchan_pkt_arb.sv
hw/vchan_egress.sv
hw/vchan_link_top.sv
sim/vchan_tb.sv
